//--- logic/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// boot vector in kseg1
`define FETCH_RESET_PC 32'hbfc00000

// must stay a power of two
`define BTB_ENTRIES 16

// cycles a request may wait for addr_ok
`define BUS_TIMEOUT 64

`endif

//--- logic/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] word_t;

    // redirect request from commit, flags then targets
    typedef struct packed {
        logic  exception_valid;
        logic  is_eret;
        logic  branch;
        logic  jump;
        logic  jr;
        word_t pcexception;
        word_t epc;
        word_t pcbranch;
        word_t pcjump;
        word_t pcjr;
    } commit_redirect_t;

    typedef struct packed {
        logic  taken;
        word_t destpc;
    } bpb_result_t;

    // one instruction handed to decode
    typedef struct packed {
        word_t       instr;
        word_t       pc;
        bpb_result_t predict;
    } fetch_slot_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t target;
    } btb_update_t;

    typedef enum logic [1:0] {
        idle,
        wait_addr,
        wait_data
    } req_state_t;

endpackage

//--- logic/redirect_select.sv
`timescale 1ns/1ns

module redirect_select (
    input  fetch_pkg::commit_redirect_t commit,
    output fetch_pkg::word_t            target,
    output logic                        redirect
);

    always_comb
    begin
        // exception > eret > branch > jump > jr
        if (commit.exception_valid)
        begin
            target = commit.pcexception;
        end
        else if (commit.is_eret)
        begin
            target = commit.epc;
        end
        else if (commit.branch)
        begin
            target = commit.pcbranch;
        end
        else if (commit.jump)
        begin
            target = commit.pcjump;
        end
        else
        begin
            target = commit.pcjr;
        end
    end

    assign redirect = commit.exception_valid | commit.is_eret | commit.branch
                    | commit.jump | commit.jr;

endmodule

//--- logic/pc_request.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module pc_request (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stall,
    input  fetch_pkg::word_t               pc_new,
    output fetch_pkg::word_t               addr,
    output fetch_pkg::word_t               pc,
    output fetch_pkg::word_t               pcplus4,
    output fetch_pkg::word_t               pcplus8,
    input  logic                           inst_ibus_addr_ok,
    output logic                           inst_ibus_req,
    output logic                           finish_pc,
    output fetch_pkg::word_t [1:0]         pc_predict,
    input  fetch_pkg::bpb_result_t [1:0]   predict_in,
    output fetch_pkg::bpb_result_t [1:0]   predict_out
);

    fetch_pkg::req_state_t state;
    logic [7:0] wait_cnt;

    always_ff @(posedge clk)
    begin
        if (~reset)
        begin
            state <= fetch_pkg::idle;
            pc    <= `FETCH_RESET_PC;
        end
        else
        begin
            case (state)
                fetch_pkg::idle:
                    state <= fetch_pkg::wait_addr;
                fetch_pkg::wait_addr:
                    if (inst_ibus_addr_ok)
                        state <= fetch_pkg::wait_data;
                default:
                    // next request once the current beat is consumed
                    if (~stall)
                    begin
                        pc    <= pc_new;
                        state <= fetch_pkg::wait_addr;
                    end
            endcase
        end
    end

    // predictions travel with the accepted request
    always_ff @(posedge clk)
    begin
        if (state == fetch_pkg::wait_addr && inst_ibus_addr_ok)
            predict_out <= predict_in;
    end

    always_ff @(posedge clk)
    begin
        if (~reset || state != fetch_pkg::wait_addr || inst_ibus_addr_ok)
            wait_cnt <= '0;
        else if (wait_cnt != 8'hff)
            wait_cnt <= wait_cnt + 8'd1;
    end

    assign pcplus4       = pc + 32'd4;
    assign pcplus8       = pc + 32'd8;
    assign addr          = pc;
    assign pc_predict    = {pcplus4, pc};
    assign inst_ibus_req = (state == fetch_pkg::wait_addr);
    assign finish_pc     = (state == fetch_pkg::wait_data);

    addr_held: assert property (@(posedge clk) disable iff (~reset)
        inst_ibus_req && ~inst_ibus_addr_ok |=> inst_ibus_req && $stable(addr));

    addr_ok_timeout: assert property (@(posedge clk) disable iff (~reset)
        wait_cnt < `BUS_TIMEOUT);

endmodule

//--- logic/instr_receive.sv
`timescale 1ns/1ns

module instr_receive (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall,
    input  fetch_pkg::word_t             pc_pcf,
    input  fetch_pkg::word_t             pcplus4_pcf,
    input  fetch_pkg::word_t             pcplus8_pcf,
    input  logic                         inst_ibus_data_ok,
    input  logic [63:0]                  inst_ibus_data,
    input  fetch_pkg::bpb_result_t [1:0] predict_in,
    input  fetch_pkg::bpb_result_t       last_predict_in,
    output fetch_pkg::fetch_slot_t [1:0] fetch_data,
    output logic [1:0]                   hitF,
    output logic                         finish_instr,
    output fetch_pkg::word_t             pc_isf,
    output fetch_pkg::word_t             pcplus4_isf,
    output fetch_pkg::word_t             pcplus8_isf,
    output fetch_pkg::bpb_result_t       predict_sel,
    output fetch_pkg::bpb_result_t       next_predict
);

    logic        valid_h;
    logic [63:0] data_h;
    logic [63:0] beat;
    logic        odd;

    always_ff @(posedge clk)
    begin
        if (~reset || ~stall)
            valid_h <= 1'b0;
        else if (inst_ibus_data_ok)
            valid_h <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (inst_ibus_data_ok)
            data_h <= inst_ibus_data;
    end

    assign finish_instr = inst_ibus_data_ok | valid_h;
    assign beat         = valid_h ? data_h : inst_ibus_data;
    // pc only moves once the held beat is consumed
    assign pc_isf       = pc_pcf;
    assign pcplus4_isf  = pcplus4_pcf;
    assign pcplus8_isf  = pcplus8_pcf;
    assign odd          = pc_isf[2];

    always_comb
    begin
        fetch_data[0].instr   = odd ? beat[63:32] : beat[31:0];
        fetch_data[0].pc      = pc_isf;
        fetch_data[0].predict = predict_in[0];
        fetch_data[1].instr   = beat[63:32];
        fetch_data[1].pc      = pcplus4_isf;
        fetch_data[1].predict = predict_in[1];
        predict_sel  = '0;
        next_predict = '0;
        if (last_predict_in.taken)
        begin
            // deliver the pending delay slot and jump
            hitF        = 2'b01;
            predict_sel = last_predict_in;
        end
        else if (odd)
        begin
            hitF = 2'b01;
            if (predict_in[0].taken)
                next_predict = predict_in[0];
        end
        else
        begin
            hitF = 2'b11;
            if (predict_in[0].taken)
                predict_sel = predict_in[0];
            else if (predict_in[1].taken)
                next_predict = predict_in[1];
        end
        // no slot holds an instruction without a beat
        if (~finish_instr)
            hitF = 2'b00;
    end

    // a second beat before the first is consumed means no request was accepted
    no_stray_data: assert property (@(posedge clk) disable iff (~reset)
        inst_ibus_data_ok |-> ~valid_h);

endmodule

//--- logic/quickfetch.sv
`timescale 1ns/1ns

module quickfetch (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stallF,
    input  fetch_pkg::commit_redirect_t  commit,
    output fetch_pkg::word_t             pc,
    output fetch_pkg::word_t             addr,
    output fetch_pkg::fetch_slot_t [1:0] fetch_data,
    output logic [1:0]                   hitF,
    output logic                         finishF,
    output fetch_pkg::word_t [1:0]       pc_predictF,
    input  fetch_pkg::bpb_result_t [1:0] destpc_predictF,
    output logic                         inst_ibus_req,
    input  logic                         inst_ibus_addr_ok,
    input  logic                         inst_ibus_data_ok,
    input  logic [63:0]                  inst_ibus_data
);

    fetch_pkg::word_t pc_cmt;
    fetch_pkg::word_t pc_cmt_h;
    fetch_pkg::word_t pc_stop;
    fetch_pkg::word_t pc_seq;
    fetch_pkg::word_t pc_new;
    fetch_pkg::word_t pc_pcf;
    fetch_pkg::word_t pcplus4_pcf;
    fetch_pkg::word_t pcplus8_pcf;
    fetch_pkg::word_t pc_isf;
    fetch_pkg::word_t pcplus4_isf;
    fetch_pkg::word_t pcplus8_isf;
    logic             pc_upd;
    logic             pc_upd_h;
    logic             stop_h;
    logic             drop;
    logic             finish_pc;
    logic             finish_instr;
    logic             advance;

    fetch_pkg::bpb_result_t [1:0] predict_pcf;
    fetch_pkg::bpb_result_t       predict_sel;
    fetch_pkg::bpb_result_t       next_predict;
    fetch_pkg::bpb_result_t       last_predict;

    redirect_select redirect_select_inst (
        .commit   (commit),
        .target   (pc_cmt),
        .redirect (pc_upd)
    );

    pc_request pc_request_inst (
        .clk               (clk),
        .reset             (reset),
        .stall             (~advance),
        .pc_new            (pc_new),
        .addr              (addr),
        .pc                (pc_pcf),
        .pcplus4           (pcplus4_pcf),
        .pcplus8           (pcplus8_pcf),
        .inst_ibus_addr_ok (inst_ibus_addr_ok),
        .inst_ibus_req     (inst_ibus_req),
        .finish_pc         (finish_pc),
        .pc_predict        (pc_predictF),
        .predict_in        (destpc_predictF),
        .predict_out       (predict_pcf)
    );

    instr_receive instr_receive_inst (
        .clk               (clk),
        .reset             (reset),
        .stall             (~advance),
        .pc_pcf            (pc_pcf),
        .pcplus4_pcf       (pcplus4_pcf),
        .pcplus8_pcf       (pcplus8_pcf),
        .inst_ibus_data_ok (inst_ibus_data_ok),
        .inst_ibus_data    (inst_ibus_data),
        .predict_in        (predict_pcf),
        .last_predict_in   (last_predict),
        .fetch_data        (fetch_data),
        .hitF              (hitF),
        .finish_instr      (finish_instr),
        .pc_isf            (pc_isf),
        .pcplus4_isf       (pcplus4_isf),
        .pcplus8_isf       (pcplus8_isf),
        .predict_sel       (predict_sel),
        .next_predict      (next_predict)
    );

    // beat in hand and decode ready, so the next request may go
    assign advance = finish_pc & finish_instr & ~stallF;
    assign finishF = advance & ~drop & ~pc_upd;

    assign pc_seq = predict_sel.taken ? predict_sel.destpc :
                    pc_isf[2]         ? pcplus4_isf        : pcplus8_isf;

    assign pc_new = pc_upd   ? pc_cmt   :
                    pc_upd_h ? pc_cmt_h :
                    stop_h   ? pc_stop  : pc_seq;

    assign pc = pc_pcf;

    always_ff @(posedge clk)
    begin
        if (~reset)
        begin
            pc_upd_h     <= 1'b0;
            stop_h       <= 1'b0;
            drop         <= 1'b0;
            last_predict <= '0;
        end
        else
        begin
            if (advance)
            begin
                pc_upd_h <= 1'b0;
                stop_h   <= 1'b0;
                drop     <= 1'b0;
            end
            else
            begin
                // the in-flight beat is stale from here on
                if (pc_upd || stallF)
                    drop <= 1'b1;
                if (pc_upd)
                    pc_upd_h <= 1'b1;
                if (stallF)
                    stop_h <= 1'b1;
            end
            if (pc_upd || (advance && pc_upd_h))
                last_predict <= '0;
            else if (finishF)
                last_predict <= next_predict;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pc_upd)
            pc_cmt_h <= pc_cmt;
        if (stallF && ~stop_h)
            pc_stop <= pc_pcf;
    end

endmodule

//--- logic/branch_target_buffer.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module branch_target_buffer (
    input  logic                          clk,
    input  logic                          reset,
    input  fetch_pkg::word_t [1:0]        lookup_pc,
    output fetch_pkg::bpb_result_t [1:0]  predict,
    input  fetch_pkg::btb_update_t        update
);

    localparam int IDX_W = $clog2(`BTB_ENTRIES);
    localparam int TAG_W = 30 - IDX_W;

    logic [`BTB_ENTRIES-1:0] valid;
    logic [TAG_W-1:0]        tag_mem [`BTB_ENTRIES];
    fetch_pkg::word_t        target_mem [`BTB_ENTRIES];
    logic [IDX_W-1:0]        wr_idx;

    assign wr_idx = update.pc[IDX_W+1:2];

    always_ff @(posedge clk)
    begin
        if (~reset)
            valid <= '0;
        else if (update.valid)
            valid[wr_idx] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (update.valid)
        begin
            tag_mem[wr_idx]    <= update.pc[31:IDX_W+2];
            target_mem[wr_idx] <= update.target;
        end
    end

    // one read port per fetch slot
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            predict[i].taken  = valid[lookup_pc[i][IDX_W+1:2]]
                && tag_mem[lookup_pc[i][IDX_W+1:2]] == lookup_pc[i][31:IDX_W+2];
            predict[i].destpc = target_mem[lookup_pc[i][IDX_W+1:2]];
        end
    end

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stallF,
    input  fetch_pkg::commit_redirect_t  commit,
    input  fetch_pkg::btb_update_t       btb_update,
    output fetch_pkg::word_t             pc,
    output fetch_pkg::fetch_slot_t [1:0] fetch_data,
    output logic [1:0]                   hitF,
    output logic                         finishF,
    output logic                         inst_ibus_req,
    output fetch_pkg::word_t             inst_ibus_addr,
    input  logic                         inst_ibus_addr_ok,
    input  logic                         inst_ibus_data_ok,
    input  logic [63:0]                  inst_ibus_data
);

    fetch_pkg::word_t [1:0]       pc_predictF;
    fetch_pkg::bpb_result_t [1:0] destpc_predictF;

    quickfetch quickfetch_inst (
        .clk               (clk),
        .reset             (reset),
        .stallF            (stallF),
        .commit            (commit),
        .pc                (pc),
        .addr              (inst_ibus_addr),
        .fetch_data        (fetch_data),
        .hitF              (hitF),
        .finishF           (finishF),
        .pc_predictF       (pc_predictF),
        .destpc_predictF   (destpc_predictF),
        .inst_ibus_req     (inst_ibus_req),
        .inst_ibus_addr_ok (inst_ibus_addr_ok),
        .inst_ibus_data_ok (inst_ibus_data_ok),
        .inst_ibus_data    (inst_ibus_data)
    );

    branch_target_buffer branch_target_buffer_inst (
        .clk       (clk),
        .reset     (reset),
        .lookup_pc (pc_predictF),
        .predict   (destpc_predictF),
        .update    (btb_update)
    );

endmodule

//--- testbench/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    // two rising edges with reset low, released on a falling edge
    initial
    begin
        reset = 1'b0;
        repeat (2)
            @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
    end

endmodule

//--- testbench/fetch_unit_tb.sv
`timescale 1ns/1ns

module fetch_unit_tb;

    localparam int DELIVERY_TIMEOUT = 64;
    localparam int RESET_TIMEOUT    = 20;

    logic                         clk;
    logic                         reset;
    logic                         stallF;
    fetch_pkg::commit_redirect_t  commit;
    fetch_pkg::btb_update_t       btb_update;
    fetch_pkg::word_t             pc;
    fetch_pkg::fetch_slot_t [1:0] fetch_data;
    logic [1:0]                   hitF;
    logic                         finishF;
    logic                         inst_ibus_req;
    fetch_pkg::word_t             inst_ibus_addr;
    logic                         inst_ibus_addr_ok = 1'b0;
    logic                         inst_ibus_data_ok = 1'b0;
    logic [63:0]                  inst_ibus_data = '0;

    integer           seed = 32'h539ec635;
    integer           bus_phase = 0;
    integer           bus_cnt = 0;
    fetch_pkg::word_t bus_addr;
    integer           checks = 0;
    integer           errors = 0;
    integer           test_checks = 0;
    integer           test_errors = 0;
    logic             aborted = 1'b0;

    clock_gen clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    fetch_unit fetch_unit_inst (
        .clk               (clk),
        .reset             (reset),
        .stallF            (stallF),
        .commit            (commit),
        .btb_update        (btb_update),
        .pc                (pc),
        .fetch_data        (fetch_data),
        .hitF              (hitF),
        .finishF           (finishF),
        .inst_ibus_req     (inst_ibus_req),
        .inst_ibus_addr    (inst_ibus_addr),
        .inst_ibus_addr_ok (inst_ibus_addr_ok),
        .inst_ibus_data_ok (inst_ibus_data_ok),
        .inst_ibus_data    (inst_ibus_data)
    );

    // memory image of the bus model
    function automatic fetch_pkg::word_t memory_word(input fetch_pkg::word_t a);
        return a ^ 32'h5a5a0000;
    endfunction

    task automatic accept_address;
        inst_ibus_addr_ok = 1'b1;
        bus_addr          = {inst_ibus_addr[31:3], 3'b000};
        bus_cnt           = 1 + {$random(seed)} % 3;
        bus_phase         = 2;
    endtask

    // bus slave with random addr_ok and data_ok delays
    always @(negedge clk)
    begin
        inst_ibus_addr_ok = 1'b0;
        inst_ibus_data_ok = 1'b0;
        if (reset !== 1'b1)
        begin
            bus_phase = 0;
        end
        else if (bus_phase == 0)
        begin
            if (inst_ibus_req === 1'b1)
            begin
                bus_cnt = {$random(seed)} % 3;
                if (bus_cnt == 0)
                    accept_address();
                else
                    bus_phase = 1;
            end
        end
        else if (bus_phase == 1)
        begin
            bus_cnt = bus_cnt - 1;
            if (bus_cnt == 0)
                accept_address();
        end
        else
        begin
            bus_cnt = bus_cnt - 1;
            if (bus_cnt == 0)
            begin
                inst_ibus_data_ok = 1'b1;
                inst_ibus_data    = {memory_word(bus_addr + 32'd4), memory_word(bus_addr)};
                bus_phase         = 0;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks      = checks + 1;
        test_checks = test_checks + 1;
        if (got !== expected)
        begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, expected);
            errors      = errors + 1;
            test_errors = test_errors + 1;
        end
    endtask

    task automatic report_test(input integer id);
        $display("test %0d done: %0d checks, %0d errors", id, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // one-cycle pulses end here
    task automatic step_cycle;
        @(negedge clk);
        stallF     = 1'b0;
        commit     = '0;
        btb_update = '0;
    endtask

    task automatic wait_reset_release;
        integer n;
        logic   done;
        n    = 0;
        done = 1'b0;
        while (!done && n < RESET_TIMEOUT)
        begin
            @(negedge clk);
            #1;
            if (reset === 1'b1)
            begin
                done = 1'b1;
            end
            else
            begin
                check_value("finishF", finishF, 32'd0);
                check_value("inst_ibus_req", inst_ibus_req, 32'd0);
                check_value("hitF", hitF, 32'd0);
                n = n + 1;
            end
        end
        if (!done)
        begin
            $display("reset was never released within %0d cycles", RESET_TIMEOUT);
            aborted = 1'b1;
        end
    endtask

    task automatic wait_delivery(input fetch_pkg::word_t exp_pc, input logic [1:0] exp_hit);
        integer n;
        n = 0;
        step_cycle();
        #1;
        while (finishF !== 1'b1 && n < DELIVERY_TIMEOUT)
        begin
            step_cycle();
            #1;
            n = n + 1;
        end
        if (finishF !== 1'b1)
        begin
            $display("no delivery within %0d cycles while waiting for pc %h",
                     DELIVERY_TIMEOUT, exp_pc);
            aborted = 1'b1;
        end
        else
        begin
            check_value("pc", pc, exp_pc);
            check_value("fetch_data[0].pc", fetch_data[0].pc, exp_pc);
            check_value("hitF", hitF, exp_hit);
            check_value("fetch_data[0].instr", fetch_data[0].instr, memory_word(exp_pc));
            if (exp_hit == 2'b11)
            begin
                check_value("fetch_data[1].pc", fetch_data[1].pc, exp_pc + 32'd4);
                check_value("fetch_data[1].instr", fetch_data[1].instr,
                            memory_word(exp_pc + 32'd4));
            end
        end
    endtask

    task automatic stall_cycles(input integer n);
        integer i;
        for (i = 0; i < n; i++)
        begin
            step_cycle();
            stallF = 1'b1;
            #1;
            check_value("finishF", finishF, 32'd0);
        end
    endtask

    // kind k targets base + k * 0x100 with exception as kind 0
    task automatic send_redirect(input logic [4:0] flags, input fetch_pkg::word_t base);
        step_cycle();
        commit.exception_valid = flags[4];
        commit.is_eret         = flags[3];
        commit.branch          = flags[2];
        commit.jump            = flags[1];
        commit.jr              = flags[0];
        commit.pcexception     = base;
        commit.epc             = base + 32'h100;
        commit.pcbranch        = base + 32'h200;
        commit.pcjump          = base + 32'h300;
        commit.pcjr            = base + 32'h400;
        #1;
        check_value("finishF", finishF, 32'd0);
    endtask

    task automatic train_btb(input fetch_pkg::word_t branch_pc, input fetch_pkg::word_t target);
        step_cycle();
        btb_update.valid  = 1'b1;
        btb_update.pc     = branch_pc;
        btb_update.target = target;
        #1;
        check_value("finishF", finishF, 32'd0);
    endtask

    initial
    begin : replay
        integer      fd;
        integer      fields;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] a;
        logic [31:0] b;
        stallF     = 1'b0;
        commit     = '0;
        btb_update = '0;
        fd         = 0;
        a          = '0;
        b          = '0;
        wait_reset_release();
        report_test(0);
        if (!aborted)
        begin
            fd = $fopen("testbench/fetch_trace.txt", "r");
            if (fd == 0)
            begin
                $display("cannot open testbench/fetch_trace.txt");
                aborted = 1'b1;
            end
        end
        while (!aborted && fd != 0 && !$feof(fd))
        begin
            cmd = 8'h23;
            if ($fgets(line, fd) != 0)
            begin
                fields = $sscanf(line, "%c %h %h", cmd, a, b);
                if (fields < 1)
                    cmd = 8'h23;
            end
            case (cmd)
                "E": wait_delivery(a, b[1:0]);
                "S": stall_cycles(a);
                "R": send_redirect(a[4:0], b);
                "T": train_btb(a, b);
                "D": report_test(a);
                8'h23, 8'h0a, 8'h0d, 8'h20: ;
                default:
                begin
                    $display("unknown trace command '%c'", cmd);
                    aborted = 1'b1;
                end
            endcase
        end
        if (fd != 0)
            $fclose(fd);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !aborted)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- testbench/fetch_trace.txt
# E pc hitF | S cycles | R flags base | T branch_pc target | D test_id, all fields hex
# R flags bits exception,eret,branch,jump,jr; target of kind k is base + k*0x100
E bfc00000 3
E bfc00008 3
E bfc00010 3
D 1
R 10 bfc00104
E bfc00104 1
E bfc00108 3
D 2
R 1f 9fc01000
E 9fc01000 3
R 0f 9fc02000
E 9fc02100 3
R 07 9fc03000
E 9fc03200 3
R 03 9fc04000
E 9fc04300 3
R 01 9fc05004
E 9fc05404 1
E 9fc05408 3
D 3
S 2
E 9fc05410 3
S 8
E 9fc05418 3
E 9fc05420 3
D 4
T 80001000 80002010
R 10 80001000
E 80001000 3
E 80002010 3
T 80003004 80004008
R 10 80003000
E 80003000 3
E 80003008 1
E 80004008 3
D 5

//--- fetch_unit.f
+incdir+logic
logic/fetch_pkg.sv
logic/redirect_select.sv
logic/pc_request.sv
logic/instr_receive.sv
logic/quickfetch.sv
logic/branch_target_buffer.sv
logic/fetch_unit.sv
testbench/clock_gen.sv
testbench/fetch_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module fetch_unit_tb \
    -f fetch_unit.f -o fetch_unit_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/fetch_unit_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported failures"; exit 1; }
echo "simulation passed"
exit 0
